/* hw/board_config.svh */
`ifndef BOARD_CONFIG_SVH
`define BOARD_CONFIG_SVH

// GPIO pin count on the board header
`define GPIO_WIDTH 12

// Cycles a reset stays asserted before release is considered
`define PRCI_HOLD_CYCLES 16

// APB address split into slave index, register word and byte lane
`define APB_ADDR_W 12
`define APB_SLV_W 4
`define APB_WORD_W 6
`define APB_BYTE_W 2

`endif

/* hw/apb_types_pkg.sv */
`include "board_config.svh"

package apb_types_pkg;

  // Slave index in the top address bits
  typedef enum logic [`APB_SLV_W-1:0] {
    SLV_PRCI = 4'd0,
    SLV_GPIO = 4'd1
  } apb_slave_e;

  typedef struct packed {
    apb_slave_e             slv;
    logic [`APB_WORD_W-1:0] word;
    logic [`APB_BYTE_W-1:0] byte_off;
  } apb_addr_fields_t;

  // One address word read raw or split into fields
  typedef union packed {
    logic [`APB_ADDR_W-1:0] flat;
    apb_addr_fields_t       fields;
  } apb_addr_u;

  // pslverr encodings
  localparam logic APB_OKAY   = 1'b0;
  localparam logic APB_SLVERR = 1'b1;

endpackage

/* hw/prci_types_pkg.sv */
`include "board_config.svh"

package prci_types_pkg;

  typedef enum logic [1:0] {
    ST_HOLD = 2'd0,
    ST_WAIT = 2'd1,
    ST_RUN  = 2'd2,
    ST_SOFT = 2'd3
  } prci_state_e;

  // Live status word read back zero-extended
  typedef struct packed {
    logic        pll_lock;
    logic        calib_done;
    logic        dbg_nrst;
    logic        sys_nrst;
    prci_state_e state;
  } prci_status_t;

  // PRCI register word offsets
  localparam logic [`APB_WORD_W-1:0] REG_STATUS = 6'd0;
  localparam logic [`APB_WORD_W-1:0] REG_CTRL   = 6'd1;

  // GPIO register word offsets
  localparam logic [`APB_WORD_W-1:0] REG_IN  = 6'd0;
  localparam logic [`APB_WORD_W-1:0] REG_OUT = 6'd1;
  localparam logic [`APB_WORD_W-1:0] REG_DIR = 6'd2;

endpackage

/* hw/apb_decoder.sv */
`timescale 1ns/1ps
`include "board_config.svh"

module apb_decoder (
  input  logic                       i_psel,
  input  logic                       i_penable,
  input  logic                       i_pwrite,
  input  apb_types_pkg::apb_addr_u   i_paddr,
  input  logic [31:0]                i_pwdata,
  output logic                       o_pready,
  output logic                       o_pslverr,
  output logic [31:0]                o_prdata,
  output logic                       o_prci_psel,
  output logic                       o_gpio_psel,
  output logic                       o_penable,
  output logic                       o_pwrite,
  output logic [`APB_WORD_W-1:0]     o_word_addr,
  output logic [31:0]                o_pwdata,
  input  logic [31:0]                i_prci_prdata,
  input  logic [31:0]                i_gpio_prdata
);

  logic hit_prci;
  logic hit_gpio;

  assign hit_prci = (i_paddr.fields.slv == apb_types_pkg::SLV_PRCI);
  assign hit_gpio = (i_paddr.fields.slv == apb_types_pkg::SLV_GPIO);

  // Unmapped indices never reach a slave
  assign o_prci_psel = i_psel & hit_prci;
  assign o_gpio_psel = i_psel & hit_gpio;

  assign o_penable   = i_penable;
  assign o_pwrite    = i_pwrite;
  assign o_word_addr = i_paddr.fields.word;
  assign o_pwdata    = i_pwdata;

  // All slaves answer in the first access cycle
  assign o_pready = i_psel & i_penable;

  always_comb begin
    o_pslverr = apb_types_pkg::APB_OKAY;
    if (hit_prci) begin
      o_prdata = i_prci_prdata;
    end else if (hit_gpio) begin
      o_prdata = i_gpio_prdata;
    end else begin
      o_prdata = '0;
      if (i_psel && i_penable) begin
        o_pslverr = apb_types_pkg::APB_SLVERR;
      end
    end
  end

endmodule

/* hw/prci_reset_ctrl.sv */
`timescale 1ns/1ps
`include "board_config.svh"

module prci_reset_ctrl (
  input  logic                         i_clk,
  input  logic                         i_arst_n,
  input  logic                         i_pll_lock,
  input  logic                         i_ddr_calib_done,
  input  logic                         i_soft_rst,
  output logic                         o_dbg_nrst,
  output logic                         o_sys_nrst,
  output prci_types_pkg::prci_status_t o_status
);

  localparam int HOLD_CNT = `PRCI_HOLD_CYCLES;
  localparam int CNT_W    = $clog2(HOLD_CNT + 1);

  prci_types_pkg::prci_state_e state_q;
  logic [CNT_W-1:0]            cnt_q;
  logic                        ready_q;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state_q    <= prci_types_pkg::ST_HOLD;
      cnt_q      <= '0;
      ready_q    <= 1'b0;
      o_dbg_nrst <= 1'b0;
      o_sys_nrst <= 1'b0;
    end else begin
      // Both board inputs must agree for a full cycle
      ready_q <= i_pll_lock & i_ddr_calib_done;
      case (state_q)
        prci_types_pkg::ST_HOLD: begin
          if (cnt_q == CNT_W'(HOLD_CNT)) begin
            state_q    <= prci_types_pkg::ST_WAIT;
            o_dbg_nrst <= 1'b1;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        prci_types_pkg::ST_WAIT: begin
          if (ready_q) begin
            state_q    <= prci_types_pkg::ST_RUN;
            o_sys_nrst <= 1'b1;
          end
        end
        prci_types_pkg::ST_RUN: begin
          // Soft reset only honoured once fully up
          if (i_soft_rst) begin
            state_q    <= prci_types_pkg::ST_SOFT;
            o_sys_nrst <= 1'b0;
            cnt_q      <= '0;
          end
        end
        prci_types_pkg::ST_SOFT: begin
          // Entry edge is already the first low cycle
          if (cnt_q == CNT_W'(HOLD_CNT - 1)) begin
            state_q <= prci_types_pkg::ST_WAIT;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
      endcase
    end
  end

  always_comb begin
    o_status.pll_lock   = i_pll_lock;
    o_status.calib_done = i_ddr_calib_done;
    o_status.dbg_nrst   = o_dbg_nrst;
    o_status.sys_nrst   = o_sys_nrst;
    o_status.state      = state_q;
  end

endmodule

/* hw/prci_regs.sv */
`timescale 1ns/1ps
`include "board_config.svh"

module prci_regs (
  input  logic                         i_clk,
  input  logic                         i_arst_n,
  input  logic                         i_psel,
  input  logic                         i_penable,
  input  logic                         i_pwrite,
  input  logic [`APB_WORD_W-1:0]       i_word_addr,
  input  logic [31:0]                  i_pwdata,
  input  prci_types_pkg::prci_status_t i_status,
  output logic [31:0]                  o_prdata,
  output logic                         o_soft_rst
);

  localparam int STATUS_W = $bits(prci_types_pkg::prci_status_t);

  logic wr_ctrl;

  assign wr_ctrl = i_psel & i_penable & i_pwrite &
                   (i_word_addr == prci_types_pkg::REG_CTRL);

  // Access phase is one cycle, so this is a single pulse
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_soft_rst <= 1'b0;
    end else begin
      o_soft_rst <= wr_ctrl & i_pwdata[0];
    end
  end

  // REG_CTRL and unused offsets read as zero
  always_comb begin
    o_prdata = '0;
    if (i_psel && (i_word_addr == prci_types_pkg::REG_STATUS)) begin
      o_prdata[STATUS_W-1:0] = i_status;
    end
  end

endmodule

/* hw/gpio_apb.sv */
`timescale 1ns/1ps
`include "board_config.svh"

module gpio_apb (
  input  logic                   i_clk,
  input  logic                   i_arst_n,
  input  logic                   i_sys_nrst,
  input  logic                   i_psel,
  input  logic                   i_penable,
  input  logic                   i_pwrite,
  input  logic [`APB_WORD_W-1:0] i_word_addr,
  input  logic [31:0]            i_pwdata,
  input  logic [`GPIO_WIDTH-1:0] i_gpio,
  output logic [31:0]            o_prdata,
  output logic [`GPIO_WIDTH-1:0] o_gpio,
  output logic [`GPIO_WIDTH-1:0] o_gpio_dir
);

  logic                   wr_en;
  logic [`GPIO_WIDTH-1:0] sync1_q;
  logic [`GPIO_WIDTH-1:0] sync2_q;

  assign wr_en = i_psel & i_penable & i_pwrite;

  // Direction bit 1 drives the pin
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_gpio     <= '0;
      o_gpio_dir <= '0;
    end else if (!i_sys_nrst) begin
      o_gpio     <= '0;
      o_gpio_dir <= '0;
    end else if (wr_en) begin
      if (i_word_addr == prci_types_pkg::REG_OUT) begin
        o_gpio <= i_pwdata[`GPIO_WIDTH-1:0];
      end
      if (i_word_addr == prci_types_pkg::REG_DIR) begin
        o_gpio_dir <= i_pwdata[`GPIO_WIDTH-1:0];
      end
    end
  end

  // Pins are asynchronous to i_clk
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      sync1_q <= '0;
      sync2_q <= '0;
    end else begin
      sync1_q <= i_gpio;
      sync2_q <= sync1_q;
    end
  end

  always_comb begin
    o_prdata = '0;
    if (i_psel) begin
      case (i_word_addr)
        prci_types_pkg::REG_IN:  o_prdata[`GPIO_WIDTH-1:0] = sync2_q;
        prci_types_pkg::REG_OUT: o_prdata[`GPIO_WIDTH-1:0] = o_gpio;
        prci_types_pkg::REG_DIR: o_prdata[`GPIO_WIDTH-1:0] = o_gpio_dir;
        default:                 o_prdata = '0;
      endcase
    end
  end

endmodule

/* hw/board_top.sv */
`timescale 1ns/1ps
`include "board_config.svh"

module board_top (
  input  logic                   i_clk,
  input  logic                   i_arst_n,
  input  logic                   i_psel,
  input  logic                   i_penable,
  input  logic                   i_pwrite,
  input  logic [`APB_ADDR_W-1:0] i_paddr,
  input  logic [31:0]            i_pwdata,
  output logic                   o_pready,
  output logic [31:0]            o_prdata,
  output logic                   o_pslverr,
  input  logic                   i_pll_lock,
  input  logic                   i_ddr_calib_done,
  input  logic [`GPIO_WIDTH-1:0] i_gpio,
  output logic [`GPIO_WIDTH-1:0] o_gpio,
  output logic [`GPIO_WIDTH-1:0] o_gpio_dir,
  output logic                   o_dbg_nrst,
  output logic                   o_sys_nrst
);

  // Decoded APB towards the slaves
  logic                         w_prci_psel;
  logic                         w_gpio_psel;
  logic                         w_penable;
  logic                         w_pwrite;
  logic [`APB_WORD_W-1:0]       w_word_addr;
  logic [31:0]                  w_pwdata;
  logic [31:0]                  w_prci_prdata;
  logic [31:0]                  w_gpio_prdata;

  logic                         w_soft_rst;
  prci_types_pkg::prci_status_t w_status;

  apb_decoder u_decoder (
    .i_psel        (i_psel),
    .i_penable     (i_penable),
    .i_pwrite      (i_pwrite),
    .i_paddr       (i_paddr),
    .i_pwdata      (i_pwdata),
    .o_pready      (o_pready),
    .o_pslverr     (o_pslverr),
    .o_prdata      (o_prdata),
    .o_prci_psel   (w_prci_psel),
    .o_gpio_psel   (w_gpio_psel),
    .o_penable     (w_penable),
    .o_pwrite      (w_pwrite),
    .o_word_addr   (w_word_addr),
    .o_pwdata      (w_pwdata),
    .i_prci_prdata (w_prci_prdata),
    .i_gpio_prdata (w_gpio_prdata)
  );

  prci_reset_ctrl u_prci_ctrl (
    .i_clk            (i_clk),
    .i_arst_n         (i_arst_n),
    .i_pll_lock       (i_pll_lock),
    .i_ddr_calib_done (i_ddr_calib_done),
    .i_soft_rst       (w_soft_rst),
    .o_dbg_nrst       (o_dbg_nrst),
    .o_sys_nrst       (o_sys_nrst),
    .o_status         (w_status)
  );

  prci_regs u_prci_regs (
    .i_clk       (i_clk),
    .i_arst_n    (i_arst_n),
    .i_psel      (w_prci_psel),
    .i_penable   (w_penable),
    .i_pwrite    (w_pwrite),
    .i_word_addr (w_word_addr),
    .i_pwdata    (w_pwdata),
    .i_status    (w_status),
    .o_prdata    (w_prci_prdata),
    .o_soft_rst  (w_soft_rst)
  );

  // GPIO sits in the system reset domain
  gpio_apb u_gpio (
    .i_clk       (i_clk),
    .i_arst_n    (i_arst_n),
    .i_sys_nrst  (o_sys_nrst),
    .i_psel      (w_gpio_psel),
    .i_penable   (w_penable),
    .i_pwrite    (w_pwrite),
    .i_word_addr (w_word_addr),
    .i_pwdata    (w_pwdata),
    .i_gpio      (i_gpio),
    .o_prdata    (w_gpio_prdata),
    .o_gpio      (o_gpio),
    .o_gpio_dir  (o_gpio_dir)
  );

endmodule

/* bench/board_top_tb.sv */
`timescale 1ns/1ps
`include "board_config.svh"

module board_top_tb;

  localparam int HOLD = `PRCI_HOLD_CYCLES;
  // Far above the roughly 170 cycles all tests need together
  localparam int MAX_CYCLES = 2000;

  logic                   i_clk = 1'b0;
  logic                   i_arst_n;
  logic                   i_psel;
  logic                   i_penable;
  logic                   i_pwrite;
  logic [`APB_ADDR_W-1:0] i_paddr;
  logic [31:0]            i_pwdata;
  logic                   o_pready;
  logic [31:0]            o_prdata;
  logic                   o_pslverr;
  logic                   i_pll_lock;
  logic                   i_ddr_calib_done;
  logic [`GPIO_WIDTH-1:0] i_gpio;
  logic [`GPIO_WIDTH-1:0] o_gpio;
  logic [`GPIO_WIDTH-1:0] o_gpio_dir;
  logic                   o_dbg_nrst;
  logic                   o_sys_nrst;

  integer seed = 32'h561a9100;
  int     cycles = 0;
  int     checks = 0;
  int     errors = 0;

  board_top i_dut (.*);

  always #20 i_clk = ~i_clk;

  always @(posedge i_clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: the run reached %0d cycles without finishing", MAX_CYCLES);
      $display("checks: %0d, errors: %0d", checks, errors + 1);
      $display("Checks failed");
      $finish;
    end
  end

  task automatic expect_eq(input string name, input logic [31:0] exp, input logic [31:0] got);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("mismatch %s: expected %h, got %h", name, exp, got);
    end
  endtask

  task automatic check_true(input logic cond, input string msg);
    checks++;
    assert (cond === 1'b1) else begin
      errors++;
      $display("%s", msg);
    end
  endtask

  // Slave index, word offset, byte lane zero
  function automatic logic [`APB_ADDR_W-1:0] reg_addr(input logic [3:0] slv,
                                                      input logic [5:0] word);
    reg_addr = {slv, word, 2'b00};
  endfunction

  task automatic apb_transfer(input logic write, input logic [`APB_ADDR_W-1:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
    int waits;
    @(posedge i_clk);
    i_psel    <= 1'b1;
    i_penable <= 1'b0;
    i_pwrite  <= write;
    i_paddr   <= addr;
    i_pwdata  <= wdata;
    @(posedge i_clk);
    i_penable <= 1'b1;
    waits = 0;
    @(negedge i_clk);
    while (!o_pready && waits < 8) begin
      @(negedge i_clk);
      waits++;
    end
    check_true(o_pready, "APB slave gave no pready within 8 access cycles");
    rdata = o_prdata;
    err   = o_pslverr;
    // Write lands on this edge
    @(posedge i_clk);
    i_psel    <= 1'b0;
    i_penable <= 1'b0;
  endtask

  task automatic apb_write(input logic [`APB_ADDR_W-1:0] addr, input logic [31:0] wdata,
                           output logic err);
    logic [31:0] unused;
    apb_transfer(1'b1, addr, wdata, unused, err);
  endtask

  task automatic apb_read(input logic [`APB_ADDR_W-1:0] addr, output logic [31:0] rdata,
                          output logic err);
    apb_transfer(1'b0, addr, 32'h0, rdata, err);
  endtask

  task automatic reset_sequence();
    int n;
    n = 0;
    do begin
      @(posedge i_clk);
      @(negedge i_clk);
      n++;
      check_true(!o_sys_nrst, "o_sys_nrst released while the ready inputs were low");
    end while (!o_dbg_nrst && n < 4 * HOLD);
    expect_eq("o_dbg_nrst release edge", HOLD + 1, n);
    @(posedge i_clk);
    i_pll_lock       <= 1'b1;
    i_ddr_calib_done <= 1'b1;
    n = 0;
    do begin
      @(posedge i_clk);
      @(negedge i_clk);
      n++;
    end while (!o_sys_nrst && n < 8);
    expect_eq("o_sys_nrst release edge", 2, n);
  endtask

  task automatic status_readback();
    logic [31:0] rdata;
    logic        err;
    apb_read(reg_addr(apb_types_pkg::SLV_PRCI, prci_types_pkg::REG_STATUS), rdata, err);
    // pll_lock, calib_done, dbg_nrst, sys_nrst, then state
    expect_eq("prdata REG_STATUS", {26'd0, 4'b1111, prci_types_pkg::ST_RUN}, rdata);
    expect_eq("pslverr REG_STATUS", 0, err);
    apb_read(reg_addr(apb_types_pkg::SLV_PRCI, prci_types_pkg::REG_CTRL), rdata, err);
    expect_eq("prdata REG_CTRL", 0, rdata);
  endtask

  task automatic gpio_roundtrip();
    logic [31:0]            rdata;
    logic [31:0]            out_wd;
    logic [31:0]            dir_wd;
    logic [`GPIO_WIDTH-1:0] in_val;
    logic                   err;
    for (int i = 0; i < 4; i++) begin
      out_wd = $random(seed);
      dir_wd = $random(seed);
      apb_write(reg_addr(apb_types_pkg::SLV_GPIO, prci_types_pkg::REG_OUT), out_wd, err);
      apb_write(reg_addr(apb_types_pkg::SLV_GPIO, prci_types_pkg::REG_DIR), dir_wd, err);
      @(negedge i_clk);
      expect_eq("o_gpio", out_wd[`GPIO_WIDTH-1:0], o_gpio);
      expect_eq("o_gpio_dir", dir_wd[`GPIO_WIDTH-1:0], o_gpio_dir);
      apb_read(reg_addr(apb_types_pkg::SLV_GPIO, prci_types_pkg::REG_OUT), rdata, err);
      expect_eq("prdata REG_OUT", 32'(out_wd[`GPIO_WIDTH-1:0]), rdata);
      apb_read(reg_addr(apb_types_pkg::SLV_GPIO, prci_types_pkg::REG_DIR), rdata, err);
      expect_eq("prdata REG_DIR", 32'(dir_wd[`GPIO_WIDTH-1:0]), rdata);
      @(posedge i_clk);
      in_val = $random(seed);
      i_gpio <= in_val;
      repeat (3) @(posedge i_clk);
      apb_read(reg_addr(apb_types_pkg::SLV_GPIO, prci_types_pkg::REG_IN), rdata, err);
      expect_eq("prdata REG_IN", 32'(in_val), rdata);
    end
  endtask

  task automatic unmapped_access();
    logic [31:0] rdata;
    logic [31:0] pins_before;
    logic [31:0] status_before;
    logic        err;
    @(negedge i_clk);
    pins_before = {o_gpio_dir, o_gpio};
    apb_read(reg_addr(apb_types_pkg::SLV_PRCI, prci_types_pkg::REG_STATUS), status_before, err);
    // Word 1 is REG_CTRL and REG_OUT, so a misroute shows
    for (int slv = 2; slv < 16; slv += 6) begin
      apb_write(reg_addr(slv, 6'd1), 32'hffff_ffff, err);
      expect_eq("pslverr unmapped write", 1, err);
      apb_read(reg_addr(slv, 6'd1), rdata, err);
      expect_eq("pslverr unmapped read", 1, err);
      expect_eq("prdata unmapped read", 0, rdata);
    end
    @(negedge i_clk);
    expect_eq("o_gpio_dir/o_gpio after unmapped writes", pins_before, {o_gpio_dir, o_gpio});
    apb_read(reg_addr(apb_types_pkg::SLV_PRCI, prci_types_pkg::REG_STATUS), rdata, err);
    expect_eq("prdata REG_STATUS after unmapped writes", status_before, rdata);
  endtask

  task automatic software_reset();
    logic [31:0] rdata;
    logic        err;
    int          t_fall;
    int          n;
    apb_write(reg_addr(apb_types_pkg::SLV_GPIO, prci_types_pkg::REG_OUT), 32'h0a5a, err);
    apb_write(reg_addr(apb_types_pkg::SLV_GPIO, prci_types_pkg::REG_DIR), 32'h0ff0, err);
    apb_write(reg_addr(apb_types_pkg::SLV_PRCI, prci_types_pkg::REG_CTRL), 32'h1, err);
    n = 0;
    do begin
      @(negedge i_clk);
      n++;
    end while (o_sys_nrst && n < 8);
    check_true(!o_sys_nrst, "o_sys_nrst did not fall after the soft reset write");
    check_true(o_dbg_nrst, "o_dbg_nrst fell during the soft reset");
    t_fall = cycles;
    @(negedge i_clk);
    expect_eq("o_gpio in soft reset", 0, o_gpio);
    expect_eq("o_gpio_dir in soft reset", 0, o_gpio_dir);
    apb_read(reg_addr(apb_types_pkg::SLV_GPIO, prci_types_pkg::REG_OUT), rdata, err);
    expect_eq("prdata REG_OUT in soft reset", 0, rdata);
    apb_read(reg_addr(apb_types_pkg::SLV_GPIO, prci_types_pkg::REG_DIR), rdata, err);
    expect_eq("prdata REG_DIR in soft reset", 0, rdata);
    apb_write(reg_addr(apb_types_pkg::SLV_GPIO, prci_types_pkg::REG_OUT), 32'h0fff, err);
    do begin
      @(negedge i_clk);
      check_true(o_dbg_nrst, "o_dbg_nrst fell during the soft reset");
    end while (!o_sys_nrst && (cycles - t_fall) < HOLD + 8);
    check_true(o_sys_nrst && (cycles - t_fall) >= HOLD && (cycles - t_fall) <= HOLD + 2,
               $sformatf("o_sys_nrst came back after %0d cycles, not %0d to %0d",
                         cycles - t_fall, HOLD, HOLD + 2));
    expect_eq("o_gpio after soft reset", 0, o_gpio);
    apb_read(reg_addr(apb_types_pkg::SLV_PRCI, prci_types_pkg::REG_STATUS), rdata, err);
    expect_eq("prdata REG_STATUS after soft reset", {26'd0, 4'b1111, prci_types_pkg::ST_RUN},
              rdata);
  endtask

  initial begin
    i_arst_n         = 1'b0;
    i_psel           = 1'b0;
    i_penable        = 1'b0;
    i_pwrite         = 1'b0;
    i_paddr          = '0;
    i_pwdata         = '0;
    i_pll_lock       = 1'b0;
    i_ddr_calib_done = 1'b0;
    i_gpio           = '0;
    repeat (5) @(posedge i_clk);
    i_arst_n <= 1'b1;
    reset_sequence();
    status_readback();
    gpio_roundtrip();
    unmapped_access();
    software_reset();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

/* project.f */
+incdir+hw
hw/apb_types_pkg.sv
hw/prci_types_pkg.sv
hw/apb_decoder.sv
hw/prci_reset_ctrl.sv
hw/prci_regs.sv
hw/gpio_apb.sv
hw/board_top.sv
bench/board_top_tb.sv
